// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -f sim.f --top-module bp_tb \
		-Mdir obj_dir -o bp_tb_sim

run: compile
	./obj_dir/bp_tb_sim > sim.log 2>&1 || true
	cat sim.log
	! grep -q "TB FAILED" sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: common/bp_pkg.sv
package bp_pkg;

    // Global history and pattern table geometry
    localparam int GHIST_LEN   = 20;
    localparam int PHT_INDEX_W = 10;
    localparam int PHT_DEPTH   = 1024;

    // Outstanding prediction buffer
    localparam int BQ_DEPTH = 8;
    localparam int BQ_PTR_W = 3;

    // Newest outcome lives in bit 0
    typedef logic [GHIST_LEN-1:0] ghist_t;

    typedef logic [PHT_INDEX_W-1:0] pht_index_t;

    // 2-bit saturating counter
    // 0 strongly not taken, 1 weakly not taken
    // 2 weakly taken, 3 strongly taken
    // Bit 1 alone gives the direction
    typedef logic [1:0] pht_entry_t;

endpackage

// File: common/bp_txn_pkg.sv
package bp_txn_pkg;

    import bp_pkg::*;

    // Fetch side request
    typedef struct packed {
        logic [31:0] pc;
    } pred_req_t;

    // Guess plus the table slot it was read from
    typedef struct packed {
        logic       taken;
        pht_index_t pht_index;
    } pred_rsp_t;

    // One outstanding branch waiting for its resolve
    typedef struct packed {
        pred_rsp_t pred;
    } bq_entry_t;

    // Back end outcome, always for the oldest branch
    typedef struct packed {
        logic taken;
    } resolve_t;

    // Commit unit state
    typedef enum logic {
        C_IDLE  = 1'b0,
        C_FLUSH = 1'b1
    } commit_state_e;

endpackage

// File: dv/bp_checker.sv
`timescale 1ns/1ps

module bp_checker
    import bp_pkg::*;
    import bp_txn_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      req_valid,
    input pred_req_t req,
    input logic      req_ready,
    input logic      rsp_valid,
    input pred_rsp_t rsp,
    input logic      res_valid,
    input resolve_t  res,
    input logic      mispredict
);

    // Reference model state
    pht_entry_t    m_pht [PHT_DEPTH];
    ghist_t        m_spec;
    ghist_t        m_commit;
    logic          m_s1_valid;
    ghist_t        m_s1_hist;
    logic [31:0]   m_s1_pc;
    commit_state_e m_cstate;
    pred_rsp_t     m_queue [$];

    int check_count = 0;
    int error_count = 0;

    // Expected guess for a pc seen with a given history
    function automatic pred_rsp_t predict(input ghist_t hist, input logic [31:0] pc);
        pred_rsp_t p;
        p.pht_index = hist[19:10] ^ hist[9:0] ^ pc[12:3];
        p.taken     = (m_pht[p.pht_index] >= 2'd2);
        return p;
    endfunction

    function automatic pht_entry_t step_counter(input pht_entry_t ctr, input logic taken);
        if (taken) begin
            return (ctr == 2'd3) ? ctr : ctr + 2'd1;
        end
        return (ctr == 2'd0) ? ctr : ctr - 2'd1;
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("** Error at %0t: %s expected %0b got %0b", $time, name, exp, act);
        end
    endtask

    task automatic check_index(input string name, input pht_index_t exp, input pht_index_t act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("** Error at %0t: %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < PHT_DEPTH; i++) begin
            m_pht[i] = 2'b00;
        end
        m_spec     = '0;
        m_commit   = '0;
        m_s1_valid = 1'b0;
        m_s1_hist  = '0;
        m_s1_pc    = '0;
        m_cstate   = C_IDLE;
        m_queue.delete();
    endtask

    // One model step per cycle, inputs and outputs stable at the edge
    always @(posedge clk) begin
        pred_rsp_t exp_rsp;
        pred_rsp_t head;
        logic      exp_rsp_valid;
        logic      exp_ready;
        logic      recovering;
        logic      mismatch;
        ghist_t    spec_next;
        if (rst) begin
            reset_model();
        end else begin
            recovering    = (m_cstate == C_FLUSH);
            exp_rsp_valid = m_s1_valid && !recovering;
            exp_ready     = !((m_queue.size() + int'(exp_rsp_valid) >= BQ_DEPTH) || recovering);
            exp_rsp       = predict(m_s1_hist, m_s1_pc);
            mismatch      = 1'b0;

            check_bit("rsp_valid", exp_rsp_valid, rsp_valid);
            check_bit("req_ready", exp_ready, req_ready);
            check_count++;
            if (mispredict !== recovering) begin
                error_count++;
                $display("** Error at %0t: mispredict expected %0b got %0b (model state %s)",
                         $time, recovering, mispredict, m_cstate.name());
            end
            if (exp_rsp_valid) begin
                check_bit("rsp.taken", exp_rsp.taken, rsp.taken);
                check_index("rsp.pht_index", exp_rsp.pht_index, rsp.pht_index);
            end

            // Recover reloads from the committed history
            if (recovering) begin
                spec_next = m_commit;
            end else if (exp_rsp_valid) begin
                spec_next = {m_spec[GHIST_LEN-2:0], exp_rsp.taken};
            end else begin
                spec_next = m_spec;
            end

            if (res_valid) begin
                if (recovering || m_queue.size() == 0) begin
                    error_count++;
                    $display("Resolve at %0t arrived with no outstanding prediction", $time);
                end else begin
                    head     = m_queue.pop_front();
                    mismatch = (head.taken != res.taken);
                    m_pht[head.pht_index] = step_counter(m_pht[head.pht_index], res.taken);
                    m_commit = {m_commit[GHIST_LEN-2:0], res.taken};
                end
            end

            if (recovering) begin
                m_queue.delete();
            end else if (exp_rsp_valid) begin
                m_queue.push_back(exp_rsp);
            end

            m_s1_valid = req_valid && exp_ready;
            if (m_s1_valid) begin
                m_s1_hist = spec_next;
                m_s1_pc   = req.pc;
            end
            m_spec   = spec_next;
            m_cstate = mismatch ? C_FLUSH : C_IDLE;
        end
    end

endmodule

// File: dv/bp_tb.sv
`timescale 1ns/1ps

module bp_tb
    import bp_pkg::*;
    import bp_txn_pkg::*;
();

    localparam int SAT_REQS   = 30;
    localparam int B2B_REQS   = 6;
    localparam int FLUSH_REQS = 9;
    localparam int NUM_REQS   = 1 + SAT_REQS + B2B_REQS + FLUSH_REQS + BQ_DEPTH + 1;
    localparam int MAX_CYCLES = 4 * NUM_REQS + 200;

    logic      clk;
    logic      rst;
    logic      req_valid;
    pred_req_t req;
    logic      req_ready;
    logic      rsp_valid;
    pred_rsp_t rsp;
    logic      res_valid;
    resolve_t  res;
    logic      mispredict;

    integer      seed = 32'h722c_b358;
    int          cycle_count = 0;
    int          tb_errors = 0;
    int          test_count = 0;
    int          flush_count = 0;
    logic [31:0] pending_pc [$];
    int          visits [logic [31:0]];

    bp_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .res_valid  (res_valid),
        .res        (res),
        .mispredict (mispredict)
    );

    bp_checker chk_i (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .res_valid  (res_valid),
        .res        (res),
        .mispredict (mispredict)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    // Taken except every fourth visit of a pc with bit 4 set
    function automatic logic branch_outcome(input logic [31:0] pc, input int visit);
        return !(pc[4] && (visit % 4 == 3));
    endfunction

    // Starts on a falling edge and returns on the one after acceptance
    task automatic issue(input logic [31:0] pc);
        req_valid = 1'b1;
        req.pc    = pc;
        while (!req_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        pending_pc.push_back(pc);
    endtask

    task automatic drain();
        req_valid = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    task automatic resolve_head(input logic shadow, input logic [31:0] shadow_pc);
        logic [31:0] pc;
        logic        shadow_on;
        pc = pending_pc.pop_front();
        if (!visits.exists(pc)) begin
            visits[pc] = 0;
        end
        res_valid  = 1'b1;
        res.taken  = branch_outcome(pc, visits[pc]);
        visits[pc] = visits[pc] + 1;
        shadow_on  = shadow && req_ready;
        // Younger request racing the resolve
        if (shadow_on) begin
            req_valid = 1'b1;
            req.pc    = shadow_pc;
        end
        @(negedge clk);
        res_valid = 1'b0;
        if (shadow) begin
            req_valid = 1'b0;
        end
        if (mispredict) begin
            flush_count++;
            pending_pc.delete();
        end else if (shadow_on) begin
            pending_pc.push_back(shadow_pc);
        end
    endtask

    task automatic resolve_all();
        while (pending_pc.size() > 0) begin
            resolve_head(1'b0, 32'h0);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        int errs;
        errs = chk_i.error_count + tb_errors - errors_before;
        test_count++;
        $display("Test %0d %s finished with %0d errors", test_count, name, errs);
    endtask

    initial begin
        logic [31:0] pc;
        int          base;
        int          flushes_before;
        int          total;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        res_valid = 1'b0;
        res       = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        base = chk_i.error_count + tb_errors;
        pc = $random(seed);
        issue(pc);
        drain();
        resolve_all();
        report_test("first_prediction", base);

        // Always taken branch so the history fills with ones
        base = chk_i.error_count + tb_errors;
        pc = $random(seed) & 32'hFFFF_FFEF;
        repeat (SAT_REQS) begin
            issue(pc);
            drain();
            resolve_all();
        end
        if (dut_i.predictor_i.pht[pc[12:3]] !== 2'd3) begin
            tb_errors++;
            $display("** Error at %0t: pht[%0h] expected 3 got %0d", $time, pc[12:3],
                     dut_i.predictor_i.pht[pc[12:3]]);
        end
        report_test("saturation", base);

        base = chk_i.error_count + tb_errors;
        repeat (B2B_REQS) begin
            pc = $random(seed);
            issue(pc);
        end
        drain();
        resolve_all();
        report_test("back_to_back", base);

        base = chk_i.error_count + tb_errors;
        flushes_before = flush_count;
        repeat (4) begin
            pc = $random(seed);
            issue(pc);
        end
        drain();
        pc = $random(seed);
        resolve_head(1'b1, pc);
        resolve_all();
        repeat (4) begin
            pc = $random(seed);
            issue(pc);
        end
        drain();
        resolve_all();
        if (flush_count == flushes_before) begin
            tb_errors++;
            $display("No mispredict was seen during the recovery test");
        end
        report_test("mispredict_recovery", base);

        base = chk_i.error_count + tb_errors;
        repeat (BQ_DEPTH) begin
            pc = $random(seed);
            issue(pc);
        end
        pc = $random(seed);
        req_valid = 1'b1;
        req.pc    = pc;
        repeat (3) begin
            if (req_ready) begin
                tb_errors++;
                $display("Request ready at %0t with eight predictions outstanding", $time);
            end
            @(negedge clk);
        end
        resolve_head(1'b0, 32'h0);
        issue(pc);
        drain();
        resolve_all();
        report_test("queue_full", base);

        repeat (4) @(negedge clk);
        total = chk_i.error_count + tb_errors;
        $display("Summary: %0d tests, %0d checks, %0d errors, %0d mispredicts",
                 test_count, chk_i.check_count, total, flush_count);
        if (total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: predictor/gshare_predictor.sv
`timescale 1ns/1ps

module gshare_predictor
    import bp_pkg::*;
    import bp_txn_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       req_valid,
    input  pred_req_t  req,
    input  logic       recover,
    input  logic       upd_valid,
    input  pht_index_t upd_index,
    input  logic       upd_taken,
    output logic       rsp_valid,
    output pred_rsp_t  rsp
);

    pht_entry_t pht [PHT_DEPTH];

    ghist_t     spec_hist;
    ghist_t     spec_next;
    ghist_t     commit_hist;

    pht_index_t s1_index;
    logic       s1_valid;
    pht_index_t req_index;

    pht_entry_t upd_old;
    pht_entry_t upd_new;

    // Fold the history onto itself, then mix in the pc
    function automatic pht_index_t hash_index(input ghist_t hist, input logic [31:0] pc);
        hash_index = hist[19:10] ^ hist[9:0] ^ pc[12:3];
    endfunction

    // Stage 1 output, table read is not registered
    assign rsp_valid     = s1_valid & ~recover;
    assign rsp.taken     = pht[s1_index][1];
    assign rsp.pht_index = s1_index;

    // Recover wins over the speculative shift
    always_comb begin
        if (recover) begin
            spec_next = commit_hist;
        end else if (rsp_valid) begin
            spec_next = {spec_hist[GHIST_LEN-2:0], rsp.taken};
        end else begin
            spec_next = spec_hist;
        end
    end

    // Forwarded history so a back-to-back request sees the guess just made
    assign req_index = hash_index(spec_next, req.pc);

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            s1_index <= req_index;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            spec_hist   <= '0;
            commit_hist <= '0;
        end else begin
            spec_hist <= spec_next;
            if (upd_valid) begin
                commit_hist <= {commit_hist[GHIST_LEN-2:0], upd_taken};
            end
        end
    end

    // Saturating step toward the real outcome
    assign upd_old = pht[upd_index];

    always_comb begin
        upd_new = upd_old;
        if (upd_taken && upd_old != 2'b11) begin
            upd_new = upd_old + 2'b01;
        end else if (!upd_taken && upd_old != 2'b00) begin
            upd_new = upd_old - 2'b01;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PHT_DEPTH; i++) begin
                pht[i] <= 2'b00;
            end
        end else if (upd_valid) begin
            pht[upd_index] <= upd_new;
        end
    end

    // Nothing is trained while the front end is being rewound
    a_no_upd_in_recover: assert property (
        @(posedge clk) disable iff (rst) recover |-> !upd_valid
    );

endmodule

// File: sim.f
common/bp_pkg.sv
common/bp_txn_pkg.sv
predictor/gshare_predictor.sv
verilog/branch_queue.sv
verilog/branch_commit.sv
verilog/bp_top.sv
dv/bp_checker.sv
dv/bp_tb.sv

// File: verilog/bp_top.sv
`timescale 1ns/1ps

module bp_top
    import bp_pkg::*;
    import bp_txn_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    input  pred_req_t req,
    output logic      req_ready,
    output logic      rsp_valid,
    output pred_rsp_t rsp,
    input  logic      res_valid,
    input  resolve_t  res,
    output logic      mispredict
);

    logic       req_fire;
    logic       full;
    logic       recover;
    logic       pop;
    logic       head_valid;
    bq_entry_t  head;
    bq_entry_t  push_entry;
    logic       upd_valid;
    pht_index_t upd_index;
    logic       upd_taken;

    assign req_ready  = ~(full | recover);
    assign req_fire   = req_valid & req_ready;
    assign mispredict = recover;

    assign push_entry.pred = rsp;

    gshare_predictor predictor_i (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_fire),
        .req       (req),
        .recover   (recover),
        .upd_valid (upd_valid),
        .upd_index (upd_index),
        .upd_taken (upd_taken),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    branch_queue queue_i (
        .clk        (clk),
        .rst        (rst),
        .push       (rsp_valid),
        .push_entry (push_entry),
        .pop        (pop),
        .flush      (recover),
        .head_valid (head_valid),
        .head       (head),
        .full       (full)
    );

    branch_commit commit_i (
        .clk        (clk),
        .rst        (rst),
        .res_valid  (res_valid),
        .res        (res),
        .head_valid (head_valid),
        .head       (head),
        .pop        (pop),
        .upd_valid  (upd_valid),
        .upd_index  (upd_index),
        .upd_taken  (upd_taken),
        .recover    (recover)
    );

endmodule

// File: verilog/branch_commit.sv
`timescale 1ns/1ps

module branch_commit
    import bp_pkg::*;
    import bp_txn_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       res_valid,
    input  resolve_t   res,
    input  logic       head_valid,
    input  bq_entry_t  head,
    output logic       pop,
    output logic       upd_valid,
    output pht_index_t upd_index,
    output logic       upd_taken,
    output logic       recover
);

    commit_state_e state;
    commit_state_e state_next;

    logic res_fire;
    logic mismatch;

    // Resolve always retires the oldest prediction
    assign res_fire = res_valid & head_valid;
    assign mismatch = res_fire & (res.taken != head.pred.taken);

    assign pop       = res_fire;
    assign upd_valid = res_fire;
    assign upd_index = head.pred.pht_index;
    assign upd_taken = res.taken;

    // Flush state is a single cycle pulse
    always_comb begin
        state_next = state;
        case (state)
            C_IDLE: begin
                if (mismatch) begin
                    state_next = C_FLUSH;
                end
            end
            C_FLUSH: begin
                state_next = C_IDLE;
            end
            default: begin
                state_next = C_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= C_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign recover = (state == C_FLUSH);

    // Back end only resolves branches that were predicted
    a_res_has_head: assert property (
        @(posedge clk) disable iff (rst) res_valid |-> head_valid
    );

endmodule

// File: verilog/branch_queue.sv
`timescale 1ns/1ps

module branch_queue
    import bp_pkg::*;
    import bp_txn_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      push,
    input  bq_entry_t push_entry,
    input  logic      pop,
    input  logic      flush,
    output logic      head_valid,
    output bq_entry_t head,
    output logic      full
);

    bq_entry_t mem [BQ_DEPTH];

    logic [BQ_PTR_W-1:0] wr_ptr;
    logic [BQ_PTR_W-1:0] rd_ptr;
    logic [BQ_PTR_W:0]   count;
    logic [BQ_PTR_W:0]   fill;

    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];

    // Counts the entry arriving this cycle, so the request that would
    // land one cycle later in stage 1 is held off in time
    assign fill = count + {{BQ_PTR_W{1'b0}}, push};
    assign full = (fill >= (BQ_PTR_W + 1)'(BQ_DEPTH));

    always_ff @(posedge clk) begin
        if (push && !flush) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + BQ_PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + BQ_PTR_W'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + (BQ_PTR_W + 1)'(1);
                2'b01:   count <= count - (BQ_PTR_W + 1)'(1);
                default: count <= count;
            endcase
        end
    end

    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst) push |-> (count < (BQ_PTR_W + 1)'(BQ_DEPTH))
    );

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst) pop |-> (count != '0)
    );

endmodule
